// ==== logic/claim_chain.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// an enabled claim stays masked while an earlier ring slice holds the output
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module claim_chain (
	input logic clock,
	input logic reset,
	input router_pkg::route_req_t req,
	input logic frame_end,
	input logic is_head,
	input router_pkg::port_mask_t claim_in,
	input router_pkg::port_mask_t out_idle,
	output router_pkg::port_mask_t claim_out,
	output router_pkg::port_mask_t grant,
	output logic yield,
	output logic busy_n
);
	import router_pkg::*;

	port_mask_t arb_in;
	port_mask_t want;
	port_mask_t held;
	logic claim_en;

	// the head slice sees every output as free of earlier holders
	assign arb_in = is_head ? '1 : claim_in;

	// one-hot of the requested output
	assign want = port_mask_t'(1) << req.addr;

	assign held = (claim_en && req.request) ? want : '0;
	assign grant = held & arb_in;

	// later slices lose the output we hold
	assign claim_out = arb_in & ~held;

	// nothing held and nothing taken
	assign yield = (claim_out == arb_in);

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			claim_en <= 1'b0;
			busy_n <= 1'b1;
		end
		else
		begin
			// low only while a request waits for its grant
			busy_n <= (|grant) || !req.request;

			if (frame_end)
				claim_en <= 1'b0;
			else if (req.request && |(want & arb_in & out_idle))
			begin
				// output is free on the ring and the old tail has left
				claim_en <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/head_rotator.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// head moves one port per cycle at most and wraps at the port count
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module head_rotator (
	input logic clock,
	input logic reset,
	input router_pkg::port_mask_t yield,
	output router_pkg::port_mask_t is_head
);
	import router_pkg::*;

	port_addr_t head_num;

	assign is_head = port_mask_t'(1) << head_num;

	always_ff @(posedge clock)
	begin
		if (!reset)
			head_num <= '0;
		else if (yield[head_num])
		begin
			// head slice holds nothing, pass priority on
			head_num <= head_num + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/header_capture.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// header bits are sampled from the registered lane, valid_n is ignored there
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module header_capture (
	input logic clock,
	input logic reset,
	input router_pkg::serial_lane_t lane,
	output router_pkg::route_req_t req,
	output logic frame_end
);
	import router_pkg::*;

	localparam int HDR_BITS = $bits(route_req_t);
	localparam int CNT_BITS = $clog2(HDR_BITS + 1);

	logic frame_d;
	logic frame_fall;
	logic shift_en;
	logic [CNT_BITS-1:0] bit_cnt;
	logic [HDR_BITS-1:0] shift_q;
	route_req_t hdr_rev;

	// edges of the registered frame_n
	assign frame_fall = frame_d & ~lane.frame_n;
	assign frame_end = ~frame_d & lane.frame_n;

	// first bit arrives together with the falling edge
	assign shift_en = frame_fall || (bit_cnt != '0 && bit_cnt < CNT_BITS'(HDR_BITS));

	// A0 went in first and sits at the top, so reverse into the address LSB
	always_comb
	begin
		hdr_rev.request = shift_q[0];
		for (int i = 0; i < $bits(port_addr_t); i++)
		begin
			hdr_rev.addr[i] = shift_q[HDR_BITS-1-i];
		end
	end

	always_ff @(posedge clock)
	begin
		if (shift_en)
		begin
			shift_q <= {shift_q[HDR_BITS-2:0], lane.data};
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			frame_d <= 1'b1;
			bit_cnt <= '0;
			req <= '0;
		end
		else
		begin
			frame_d <= lane.frame_n;
			if (frame_end)
			begin
				bit_cnt <= '0;
				req <= '0;
			end
			else if (frame_fall)
				bit_cnt <= CNT_BITS'(1);
			else if (shift_en)
				bit_cnt <= bit_cnt + 1'b1;
			else if (bit_cnt == CNT_BITS'(HDR_BITS))
			begin
				// whole header is in, hold it until the frame ends
				req <= hdr_rev;
				bit_cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/input_slice.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bits offered while busy_n is low are marked invalid and never forwarded
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module input_slice (
	input logic clock,
	input logic reset,
	input logic frame_n,
	input logic valid_n,
	input logic din,
	input logic is_head,
	input router_pkg::port_mask_t claim_in,
	input router_pkg::port_mask_t out_idle,
	output router_pkg::port_mask_t claim_out,
	output router_pkg::port_mask_t grant,
	output logic yield,
	output router_pkg::serial_lane_t lane,
	output logic busy_n
);
	import router_pkg::*;

	serial_lane_t lane_d;
	route_req_t req;
	logic frame_end;

	// a bit is only taken while busy_n is high
	assign lane_d.frame_n = frame_n;
	assign lane_d.valid_n = valid_n | ~busy_n;
	assign lane_d.data = din;

	always_ff @(posedge clock)
	begin
		if (!reset)
			lane <= LANE_IDLE;
		else
			lane <= lane_d;
	end

	header_capture i_capture (
		.clock(clock),
		.reset(reset),
		.lane(lane),
		.req(req),
		.frame_end(frame_end)
	);

	claim_chain i_claim (
		.clock(clock),
		.reset(reset),
		.req(req),
		.frame_end(frame_end),
		.is_head(is_head),
		.claim_in(claim_in),
		.out_idle(out_idle),
		.claim_out(claim_out),
		.grant(grant),
		.yield(yield),
		.busy_n(busy_n)
	);

endmodule

`default_nettype wire

// ==== logic/output_crossbar.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// expects at most one granted slice per output, otherwise lanes are merged
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "router_params.svh"
`default_nettype none

module output_crossbar (
	input logic clock,
	input logic reset,
	input router_pkg::port_mask_t grant [`ROUTER_PORTS],
	input router_pkg::serial_lane_t lane [`ROUTER_PORTS],
	output router_pkg::port_mask_t frameo_n,
	output router_pkg::port_mask_t valido_n,
	output router_pkg::port_mask_t dout
);
	import router_pkg::*;

	serial_lane_t merged [`ROUTER_PORTS];

	// active-low signals merge by AND, data by OR
	always_comb
	begin
		for (int d = 0; d < `ROUTER_PORTS; d++)
		begin
			merged[d] = LANE_IDLE;
			for (int s = 0; s < `ROUTER_PORTS; s++)
			begin
				if (grant[s][d])
				begin
					merged[d].frame_n = merged[d].frame_n & lane[s].frame_n;
					merged[d].valid_n = merged[d].valid_n & lane[s].valid_n;
					merged[d].data = merged[d].data | lane[s].data;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			frameo_n <= '1;
			valido_n <= '1;
			dout <= '0;
		end
		else
		begin
			for (int d = 0; d < `ROUTER_PORTS; d++)
			begin
				frameo_n[d] <= merged[d].frame_n;
				valido_n[d] <= merged[d].valid_n;
				dout[d] <= merged[d].data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/router.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// payload reaches dout two cycles after it is taken, header bits never do
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "router_params.svh"
`default_nettype none

module router (
	input logic clock,
	input logic reset,
	input router_pkg::port_mask_t frame_n,
	input router_pkg::port_mask_t valid_n,
	input router_pkg::port_mask_t din,
	output router_pkg::port_mask_t busy_n,
	output router_pkg::port_mask_t frameo_n,
	output router_pkg::port_mask_t valido_n,
	output router_pkg::port_mask_t dout
);
	import router_pkg::*;

	// claim_ring[s] is what slice s passes to slice s+1
	port_mask_t claim_ring [`ROUTER_PORTS];
	port_mask_t grant [`ROUTER_PORTS];
	serial_lane_t lane [`ROUTER_PORTS];
	port_mask_t yield;
	port_mask_t is_head;

	for (genvar s = 0; s < `ROUTER_PORTS; s++)
	begin : g_slice
		input_slice i_slice (
			.clock(clock),
			.reset(reset),
			.frame_n(frame_n[s]),
			.valid_n(valid_n[s]),
			.din(din[s]),
			.is_head(is_head[s]),
			.claim_in(claim_ring[(s + `ROUTER_PORTS - 1) % `ROUTER_PORTS]),
			// registered frameo_n high means the output is idle
			.out_idle(frameo_n),
			.claim_out(claim_ring[s]),
			.grant(grant[s]),
			.yield(yield[s]),
			.lane(lane[s]),
			.busy_n(busy_n[s])
		);
	end

	head_rotator i_head (
		.clock(clock),
		.reset(reset),
		.yield(yield),
		.is_head(is_head)
	);

	output_crossbar i_xbar (
		.clock(clock),
		.reset(reset),
		.grant(grant),
		.lane(lane),
		.frameo_n(frameo_n),
		.valido_n(valido_n),
		.dout(dout)
	);

endmodule

`default_nettype wire

// ==== logic/router_params.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ROUTER_ADDR_BITS must equal log2 of ROUTER_PORTS
// the head counter and address decode wrap on that width
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

`default_nettype none

// serial input ports, and the same number of output ports
`define ROUTER_PORTS 16

// header address bits, A0 is sent first
`define ROUTER_ADDR_BITS 4

`default_nettype wire

`endif

// ==== logic/router_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lane signals are active low except data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "router_params.svh"
`default_nettype none

package router_pkg;

	// one bit per output port
	typedef logic [`ROUTER_PORTS-1:0] port_mask_t;

	// output port number
	typedef logic [`ROUTER_ADDR_BITS-1:0] port_addr_t;

	typedef struct packed {
		logic frame_n;
		logic valid_n;
		logic data;
	} serial_lane_t;

	// no frame, no valid bit
	localparam serial_lane_t LANE_IDLE = '{frame_n: 1'b1, valid_n: 1'b1, data: 1'b0};

	// captured header, request is the fifth header bit
	typedef struct packed {
		logic request;
		port_addr_t addr;
	} route_req_t;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/router_pkg.sv
logic/header_capture.sv
logic/claim_chain.sv
logic/input_slice.sv
logic/head_rotator.sv
logic/output_crossbar.sv
logic/router.sv
verif/router_assertions.sv
verif/router_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the router testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module router_tb -o router_sim &&
./obj_dir/router_sim ||
{ echo "simulation failed"; exit 1; }

// ==== verif/router_assertions.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// checks output framing and the busy_n hold rule on every port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "router_params.svh"
`default_nettype none

module router_assertions (
	input logic clock,
	input logic reset,
	input router_pkg::port_mask_t frame_n,
	input router_pkg::port_mask_t busy_n,
	input router_pkg::port_mask_t frameo_n,
	input router_pkg::port_mask_t valido_n
);
	import router_pkg::*;

	port_mask_t busy_q;
	port_mask_t granted;

	// granted marks a busy_n that rose inside the current frame
	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			busy_q <= '1;
			granted <= '0;
		end
		else
		begin
			busy_q <= busy_n;
			granted <= ~frame_n & (granted | (busy_n & ~busy_q));
		end
	end

	for (genvar p = 0; p < `ROUTER_PORTS; p++)
	begin : g_port
		// a valid bit never leaves outside a frame
		valid_in_frame: assert property (@(posedge clock) disable iff (!reset)
			!valido_n[p] |-> !frameo_n[p])
		else
			$error("valido_n[%0d] low while frameo_n is high", p);

		busy_held: assert property (@(posedge clock) disable iff (!reset)
			granted[p] && !frame_n[p] |-> busy_n[p])
		else
			$error("busy_n[%0d] fell again before frame_n rose", p);
	end

endmodule

bind router router_assertions i_router_assertions (
	.clock(clock),
	.reset(reset),
	.frame_n(frame_n),
	.busy_n(busy_n),
	.frameo_n(frameo_n),
	.valido_n(valido_n)
);

`default_nettype wire

// ==== verif/router_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sources drive on the falling edge and only advance while busy_n is high
// outputs are sampled on the falling edge, one expected packet per frame
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "router_params.svh"
`default_nettype none

module router_tb;
	import router_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NPORT = `ROUTER_PORTS;

	logic clock;
	logic reset;
	port_mask_t frame_n;
	port_mask_t valid_n;
	port_mask_t din;
	port_mask_t busy_n;
	port_mask_t frameo_n;
	port_mask_t valido_n;
	port_mask_t dout;

	logic [31:0] lcg_state;
	int budget_cycles;
	int senders_done;
	int frames_seen;
	int error_count;
	int wait_cycles [NPORT];
	int perm [NPORT];
	int pkt_len [NPORT];

	// per source, every payload cycle as it was offered
	bit offer_data [NPORT][$];
	bit offer_valid_n [NPORT][$];
	bit offer_busy_n [NPORT][$];

	// per output, expected bits and packet lengths in arrival order
	bit exp_bits [NPORT][$];
	int exp_len [NPORT][$];

	bit in_frame [NPORT];
	bit got_bits [NPORT][$];

	router i_router (
		.clock(clock),
		.reset(reset),
		.frame_n(frame_n),
		.valid_n(valid_n),
		.din(din),
		.busy_n(busy_n),
		.frameo_n(frameo_n),
		.valido_n(valido_n),
		.dout(dout)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// a payload bit counts only if valid_n was low and busy_n high when offered
	function automatic void build_expected(input int src, input int dst, input bit request);
		int n;
		n = 0;
		if (request)
		begin
			for (int i = 0; i < offer_data[src].size(); i++)
			begin
				if (!offer_valid_n[src][i] && offer_busy_n[src][i])
				begin
					exp_bits[dst].push_back(offer_data[src][i]);
					n++;
				end
			end
			exp_len[dst].push_back(n);
		end
		offer_data[src].delete();
		offer_valid_n[src].delete();
		offer_busy_n[src].delete();
	endfunction

	function automatic int frames_pending();
		int n;
		n = 0;
		for (int d = 0; d < NPORT; d++)
			n += exp_len[d].size() + int'(in_frame[d]);
		return n;
	endfunction

	task automatic abort_run(input string why);
		error_count++;
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input int got, input int want);
		if (got !== want)
			abort_run($sformatf("MISMATCH at %0t ns: %s got %0h expected %0h",
				$time, name, got, want));
	endtask

	// header A0 first, then the request flag, three pads, then payload
	task automatic send_packet(input int src, input int dst, input bit request,
		input int len, input int gap_level);
		logic [31:0] r;
		bit pending;
		int sent;
		for (int i = 0; i < 5; i++)
		begin
			@(negedge clock);
			frame_n[src] = 1'b0;
			valid_n[src] = 1'b1;
			din[src] = (i < 4) ? dst[i] : request;
		end
		repeat (3)
		begin
			@(negedge clock);
			din[src] = 1'b0;
		end
		sent = 0;
		pending = lcg_next() >> 16;
		while (sent < len)
		begin
			@(negedge clock);
			r = lcg_next();
			if (!busy_n[src])
				wait_cycles[src]++;
			if (int'(r[31:29]) < gap_level || !busy_n[src])
			begin
				// gap or back-pressure, the wire carries the wrong bit
				valid_n[src] = busy_n[src] ? 1'b1 : r[28];
				din[src] = ~pending;
			end
			else
			begin
				valid_n[src] = 1'b0;
				din[src] = pending;
				pending = r[7];
				sent++;
			end
			offer_data[src].push_back(din[src]);
			offer_valid_n[src].push_back(valid_n[src]);
			offer_busy_n[src].push_back(busy_n[src]);
		end
		@(negedge clock);
		frame_n[src] = 1'b1;
		valid_n[src] = 1'b1;
		din[src] = 1'b0;
		build_expected(src, dst, request);
		repeat (2) @(negedge clock);
		senders_done++;
	endtask

	task automatic launch_sender(input int src);
		fork
			send_packet(src, perm[src], 1'b1, pkt_len[src], 2);
		join_none
	endtask

	task automatic compare_frame(input int d);
		int n;
		if (exp_len[d].size() == 0)
			abort_run($sformatf("output %0d carried a frame that no source sent", d));
		else
		begin
			n = exp_len[d].pop_front();
			check_value($sformatf("frame length on dout[%0d]", d), got_bits[d].size(), n);
			for (int i = 0; i < n; i++)
				check_value($sformatf("dout[%0d] bit %0d", d, i), int'(got_bits[d][i]),
					int'(exp_bits[d].pop_front()));
			got_bits[d].delete();
			frames_seen++;
		end
	endtask

	task automatic drain_outputs();
		while (frames_pending() != 0)
			@(negedge clock);
		repeat (4) @(negedge clock);
	endtask

	// compare process, one frame per output at a time
	always @(negedge clock)
	begin
		if (reset)
		begin
			for (int d = 0; d < NPORT; d++)
			begin
				if (!valido_n[d] && frameo_n[d])
					abort_run($sformatf("valido_n[%0d] low outside an output frame", d));
				if (!frameo_n[d])
				begin
					in_frame[d] = 1'b1;
					if (!valido_n[d])
						got_bits[d].push_back(dout[d]);
				end
				else if (in_frame[d])
				begin
					in_frame[d] = 1'b0;
					compare_frame(d);
				end
			end
		end
	end

	initial
	begin
		wait (budget_cycles != 0);
		repeat (budget_cycles) @(posedge clock);
		abort_run("watchdog expired before all packets were delivered");
	end

	initial
	begin
		int total;
		int j;
		int t;
		reset = 1'b0;
		frame_n = '1;
		valid_n = '1;
		din = '0;
		lcg_state = 32'h65afc924;
		senders_done = 0;
		frames_seen = 0;
		error_count = 0;
		budget_cycles = 0;
		for (int i = 0; i < NPORT; i++)
		begin
			perm[i] = i;
			wait_cycles[i] = 0;
			in_frame[i] = 1'b0;
			pkt_len[i] = 4 + int'(lcg_next() >> 8) % 16;
		end
		// shuffle into a permutation of the outputs
		for (int i = NPORT - 1; i > 0; i--)
		begin
			j = int'(lcg_next() >> 8) % (i + 1);
			t = perm[i];
			perm[i] = perm[j];
			perm[j] = t;
		end
		total = (12 + 8) + (8 + 8) + 2 * (16 + 8) + (10 + 8);
		for (int i = 0; i < NPORT; i++)
			total += pkt_len[i] + 8;
		budget_cycles = total * 40 + 200;

		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b1;
		@(negedge clock);
		check_value("busy_n after reset", int'(busy_n), 32'hffff);
		check_value("frameo_n after reset", int'(frameo_n), 32'hffff);
		check_value("valido_n after reset", int'(valido_n), 32'hffff);
		check_value("dout after reset", int'(dout), 0);

		// single packet, port 3 to output 9
		send_packet(3, 9, 1'b1, 12, 1);
		drain_outputs();
		check_value("frameo_n after packet", int'(frameo_n), 32'hffff);
		check_value("frames on dout[9]", frames_seen, 1);

		// request flag clear, nothing may leave the router
		send_packet(7, 5, 1'b0, 8, 1);
		repeat (20) @(negedge clock);
		check_value("frames after empty request", frames_seen, 1);
		check_value("valido_n after empty request", int'(valido_n), 32'hffff);

		// two sources on output 11, the later one has to wait
		wait_cycles[2] = 0;
		fork
			send_packet(6, 11, 1'b1, 16, 1);
			begin
				repeat (3) @(negedge clock);
				send_packet(2, 11, 1'b1, 16, 1);
			end
		join
		drain_outputs();
		check_value("busy_n[2] held low while output 11 was taken",
			int'(wait_cycles[2] >= 10), 1);
		check_value("frames after contention", frames_seen, 3);

		// every source at once on a random permutation
		senders_done = 0;
		for (int s = 0; s < NPORT; s++)
			launch_sender(s);
		while (senders_done < NPORT)
			@(negedge clock);
		drain_outputs();
		check_value("frames after permutation", frames_seen, 3 + NPORT);

		// heavy valid gaps, only taken bits may appear
		send_packet(12, 0, 1'b1, 10, 5);
		drain_outputs();
		check_value("frames after gap test", frames_seen, 4 + NPORT);

		if (error_count == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
		begin
			$display("FAIL: see errors above");
			$fatal(1, "errors were counted");
		end
	end

endmodule

`default_nettype wire
